// ==== include/apu_macros.svh ====
// APU register map and timing constants
// Addresses of the kept channel 3 and global registers, the wave RAM window,
// the length tick divider and the output padding
`ifndef APU_MACROS_SVH
`define APU_MACROS_SVH

//////////////////////////////
// Channel 3 registers
`define APU_ADDR_NR30 16'hFF1A  // DAC enable
`define APU_ADDR_NR31 16'hFF1B  // Length load
`define APU_ADDR_NR32 16'hFF1C  // Output level code
`define APU_ADDR_NR33 16'hFF1D  // Period low byte
`define APU_ADDR_NR34 16'hFF1E  // Period high bits and control

//////////////////////////////
// Global registers
`define APU_ADDR_NR50 16'hFF24  // Master volume
`define APU_ADDR_NR51 16'hFF25  // Panning
`define APU_ADDR_NR52 16'hFF26  // Master power and on flags

// Wave RAM window, 16 bytes
`define APU_WAVE_BASE 16'hFF30
`define APU_WAVE_LAST 16'hFF3F

// Cycles per length step, scaled down from 256 Hz
`define APU_LEN_TICK_CYCLES 64

// Value seen on unmapped or blocked reads
`define APU_READ_DEFAULT 8'hFF

// Zero bits below the mixed sample in the 16 bit outputs
`define APU_OUT_PAD 6'b00_0000

`endif

// ==== verilog/apu_reg_pkg.sv ====
// Register side types of the APU
// Channel 3 settings, mixer control and the two views of a CPU byte
package apu_reg_pkg;

    // Channel 3 settings taken from NR30..NR34
    typedef struct packed {
        logic        dac_on;       // NR30 bit 7
        logic [7:0]  length_load;  // NR31
        logic [1:0]  vol_code;     // NR32 bits 6:5
        logic [10:0] frequency;    // NR34 bits 2:0 and NR33
        logic        length_en;    // NR34 bit 6
    } ch3_cfg_t;

    // Mixer control from NR50, NR51 and the power bit
    typedef struct packed {
        logic       left_en;      // NR51 bit 6
        logic       right_en;     // NR51 bit 2
        logic [2:0] left_level;   // NR50 bits 6:4
        logic [2:0] right_level;  // NR50 bits 2:0
        logic       power;        // NR52 bit 7
    } mix_ctl_t;

    // NR34 layout
    typedef struct packed {
        logic       trigger;    // Restart the channel
        logic       length_en;  // Stop at length expiry
        logic [2:0] unused;
        logic [2:0] freq_hi;    // Period bits 10:8
    } nr34_ctrl_t;

    // NR52 layout, only power is writable
    typedef struct packed {
        logic       power;
        logic [6:0] unused;
    } nr52_master_t;

    // One byte, decoded as channel control or master control
    typedef union packed {
        nr34_ctrl_t   ctrl;
        nr52_master_t master;
    } wr_byte_u;

endpackage

// ==== verilog/apu_audio_pkg.sv ====
// Sample side types of the APU
// Wave samples, playback position and the stereo output pair
package apu_audio_pkg;

    typedef logic [3:0] nibble_t;    // One 4 bit wave sample
    typedef logic [4:0] wave_pos_t;  // 32 samples per wave

    // Padded output pair
    typedef struct packed {
        logic [15:0] left;
        logic [15:0] right;
    } stereo_t;

endpackage

// ==== verilog/apu_regs.sv ====
// APU register file
// Decodes CPU accesses, keeps the channel 3 and global registers, handles
// master power clear and produces the one cycle channel trigger
`include "apu_macros.svh"

module apu_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [15:0]           addr_i,
    input  logic [7:0]            data_i,
    input  logic                  wren_i,
    input  logic                  ch3_on_i,
    input  logic [7:0]            wave_rdata_i,
    output logic [7:0]            data_o,
    output apu_reg_pkg::ch3_cfg_t cfg_o,
    output apu_reg_pkg::mix_ctl_t mix_o,
    output logic                  trigger_o,
    output logic                  wave_we_o
);
    import apu_reg_pkg::*;

    // Kept registers
    logic [7:0] nr30_q, nr31_q, nr32_q, nr33_q;
    wr_byte_u   nr34_q;  // Decoded through the control view
    logic [7:0] nr50_q, nr51_q;
    logic       power_q;  // NR52 bit 7

    wr_byte_u wr_byte;    // CPU write byte, two decodings
    logic     in_wave;
    logic     clear_all;
    logic     trigger_q;

    assign wr_byte = data_i;
    assign in_wave = (addr_i >= `APU_WAVE_BASE) && (addr_i <= `APU_WAVE_LAST);

    // Power bit cleared by the CPU wipes the whole register file
    assign clear_all = wren_i && (addr_i == `APU_ADDR_NR52) && !wr_byte.master.power;

    //////////////////////////////
    // CPU writes

    always_ff @(posedge clk) begin
        if (reset || clear_all) begin
            nr30_q  <= 8'h00;
            nr31_q  <= 8'h00;
            nr32_q  <= 8'h00;
            nr33_q  <= 8'h00;
            nr34_q  <= '0;
            nr50_q  <= 8'h00;
            nr51_q  <= 8'h00;
            power_q <= 1'b0;
        end else if (wren_i) begin
            if (addr_i == `APU_ADDR_NR52) begin
                power_q <= 1'b1;  // Only a set power bit gets here
            end else if (power_q) begin  // Other writes dropped while off
                case (addr_i)
                    `APU_ADDR_NR30: nr30_q <= data_i;
                    `APU_ADDR_NR31: nr31_q <= data_i;
                    `APU_ADDR_NR32: nr32_q <= data_i;
                    `APU_ADDR_NR33: nr33_q <= data_i;
                    `APU_ADDR_NR34: nr34_q <= wr_byte;
                    `APU_ADDR_NR50: nr50_q <= data_i;
                    `APU_ADDR_NR51: nr51_q <= data_i;
                    default: ;  // Unused or dropped channel address
                endcase
            end
        end
    end

    // Trigger pulse, high for the cycle after the NR34 write
    always_ff @(posedge clk) begin
        if (reset) begin
            trigger_q <= 1'b0;
        end else begin
            trigger_q <= wren_i && power_q && (addr_i == `APU_ADDR_NR34)
                         && wr_byte.ctrl.trigger;
        end
    end

    assign trigger_o = trigger_q;
    assign wave_we_o = wren_i && in_wave;  // RAM itself blocks when channel owns it

    //////////////////////////////
    // CPU reads

    always_comb begin
        if (in_wave) begin
            data_o = wave_rdata_i;
        end else begin
            case (addr_i)
                `APU_ADDR_NR30: data_o = nr30_q;
                `APU_ADDR_NR31: data_o = nr31_q;
                `APU_ADDR_NR32: data_o = nr32_q;
                `APU_ADDR_NR33: data_o = nr33_q;
                `APU_ADDR_NR34: data_o = nr34_q;
                `APU_ADDR_NR50: data_o = nr50_q;
                `APU_ADDR_NR51: data_o = nr51_q;
                `APU_ADDR_NR52: data_o = {power_q, 3'b000, 1'b0, ch3_on_i, 2'b00};
                default:        data_o = `APU_READ_DEFAULT;
            endcase
        end
    end

    //////////////////////////////
    // Field extraction

    always_comb begin
        cfg_o.dac_on      = nr30_q[7];
        cfg_o.length_load = nr31_q;
        cfg_o.vol_code    = nr32_q[6:5];
        cfg_o.frequency   = {nr34_q.ctrl.freq_hi, nr33_q};
        cfg_o.length_en   = nr34_q.ctrl.length_en;

        mix_o.left_en     = nr51_q[6];  // Channel 3 to the left
        mix_o.right_en    = nr51_q[2];  // Channel 3 to the right
        mix_o.left_level  = nr50_q[6:4];
        mix_o.right_level = nr50_q[2:0];
        mix_o.power       = power_q;
    end

endmodule

// ==== verilog/wave_ram.sv ====
// Wave RAM
// 16 bytes of sample memory shared by the CPU and channel 3;
// the channel has the RAM whenever its DAC is on
`include "apu_macros.svh"

module wave_ram (
    input  logic       clk,
    input  logic [3:0] cpu_addr_i,
    input  logic [7:0] cpu_wdata_i,
    input  logic       cpu_we_i,
    input  logic [3:0] chan_addr_i,
    input  logic       chan_owns_i,
    output logic [7:0] cpu_rdata_o,
    output logic [7:0] chan_rdata_o
);

    logic [7:0] mem [16];
    logic [3:0] rd_addr;
    logic [7:0] rd_byte;

    // Single read port, owner picks the address
    assign rd_addr = chan_owns_i ? chan_addr_i : cpu_addr_i;
    assign rd_byte = mem[rd_addr];

    assign cpu_rdata_o  = chan_owns_i ? `APU_READ_DEFAULT : rd_byte;  // Blocked while playing
    assign chan_rdata_o = rd_byte;

    // CPU writes only land while the channel is off the RAM
    always_ff @(posedge clk) begin
        if (cpu_we_i && !chan_owns_i) begin
            mem[cpu_addr_i] <= cpu_wdata_i;
        end
    end

endmodule

// ==== verilog/frame_sequencer.sv ====
// Frame sequencer, length step only
// Free running divider giving a one cycle length tick per wrap
`include "apu_macros.svh"

module frame_sequencer (
    input  logic clk,
    input  logic reset,
    output logic len_tick_o
);

    localparam int unsigned CNT_W = $clog2(`APU_LEN_TICK_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`APU_LEN_TICK_CYCLES - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             tick_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            tick_q <= (cnt_q == CNT_LAST);  // One cycle at wrap
            if (cnt_q == CNT_LAST) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign len_tick_o = tick_q;

endmodule

// ==== verilog/wave_channel.sv ====
// Channel 3, custom wave
// Steps through 32 nibbles of wave RAM at the programmed period, applies the
// volume code and stops on length expiry, DAC off or power off
module wave_channel (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  power_i,
    input  apu_reg_pkg::ch3_cfg_t cfg_i,
    input  logic                  trigger_i,
    input  logic                  len_tick_i,
    input  logic [7:0]            wave_byte_i,
    output logic [3:0]            wave_addr_o,
    output apu_audio_pkg::nibble_t level_o,
    output logic                  ch3_on_o
);
    import apu_audio_pkg::*;

    logic        on_q;
    wave_pos_t   pos_q;         // Nibble position in the wave
    logic [11:0] period_cnt_q;  // Cycles left in this sample, up to 2048
    logic [8:0]  len_cnt_q;     // Length steps left, up to 256
    logic [11:0] period_load;
    nibble_t     sample;
    nibble_t     scaled;
    nibble_t     level_q;

    assign period_load = 12'd2048 - {1'b0, cfg_i.frequency};

    //////////////////////////////
    // Sample path

    assign wave_addr_o = pos_q[4:1];  // Two nibbles per byte
    assign sample = pos_q[0] ? wave_byte_i[3:0] : wave_byte_i[7:4];  // High nibble first

    always_comb begin
        case (cfg_i.vol_code)
            2'd0:    scaled = 4'd0;       // Mute
            2'd1:    scaled = sample;     // Full
            2'd2:    scaled = sample >> 1;  // Half
            default: scaled = sample >> 2;  // Quarter
        endcase
    end

    // Level lags the position by one cycle
    always_ff @(posedge clk) begin
        level_q <= scaled;
    end

    //////////////////////////////
    // Timer, position, length

    always_ff @(posedge clk) begin
        if (reset || !power_i || !cfg_i.dac_on) begin
            on_q         <= 1'b0;
            pos_q        <= '0;
            period_cnt_q <= '0;
            len_cnt_q    <= '0;
        end else if (trigger_i) begin
            on_q         <= 1'b1;
            pos_q        <= '0;
            period_cnt_q <= period_load;
            len_cnt_q    <= 9'd256 - {1'b0, cfg_i.length_load};
        end else if (on_q) begin
            // Period timer
            if (period_cnt_q <= 12'd1) begin
                period_cnt_q <= period_load;
                pos_q        <= pos_q + 1'b1;  // Wraps at 32
            end else begin
                period_cnt_q <= period_cnt_q - 1'b1;
            end

            // Length counter, stops the channel at zero
            if (len_tick_i && cfg_i.length_en) begin
                len_cnt_q <= len_cnt_q - 1'b1;
                if (len_cnt_q <= 9'd1) begin
                    on_q      <= 1'b0;
                    len_cnt_q <= '0;
                end
            end
        end
    end

    assign level_o  = level_q;
    assign ch3_on_o = on_q;

endmodule

// ==== verilog/stereo_mixer.sv ====
// Stereo mixer for channel 3
// Pans per NR51, scales by the NR50 levels, pads to 16 bits and
// mutes everything when power or the channel is off
`include "apu_macros.svh"

module stereo_mixer (
    input  apu_audio_pkg::nibble_t level_i,
    input  logic                   ch3_on_i,
    input  apu_reg_pkg::mix_ctl_t  mix_i,
    output apu_audio_pkg::stereo_t out_o
);
    import apu_audio_pkg::*;

    logic gate;

    // One side, pan then master volume then padding
    function automatic logic [15:0] mix_side(input nibble_t level, input logic en,
                                             input logic [2:0] vol);
        logic [6:0] prod;
        prod = (en ? {3'b000, level} : 7'd0) * {4'b0000, vol};  // Max 15 x 7
        return {3'b000, prod, `APU_OUT_PAD};
    endfunction

    assign gate = mix_i.power && ch3_on_i;

    always_comb begin
        out_o.left  = gate ? mix_side(level_i, mix_i.left_en, mix_i.left_level) : 16'h0000;
        out_o.right = gate ? mix_side(level_i, mix_i.right_en, mix_i.right_level) : 16'h0000;
    end

endmodule

// ==== verilog/apu_top.sv ====
// Reduced Game Boy APU
// Register file, wave RAM, length sequencer, custom wave channel and
// stereo mixer on one CPU bus
module apu_top (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] addr_i,
    input  logic [7:0]  data_i,
    input  logic        wren_i,
    output logic [7:0]  data_o,
    output logic [15:0] left_o,
    output logic [15:0] right_o
);
    import apu_reg_pkg::*;
    import apu_audio_pkg::*;

    ch3_cfg_t   cfg;             // Channel 3 settings
    mix_ctl_t   mix;             // Panning, levels, power
    logic       trigger;         // NR34 restart pulse
    logic       len_tick;
    logic       wave_we;
    logic [7:0] wave_cpu_rdata;
    logic [7:0] wave_chan_rdata;
    logic [3:0] wave_addr;       // Channel side byte address
    nibble_t    level;
    logic       ch3_on;
    stereo_t    out;

    ////////////////////////////////
    // Control

    apu_regs regs_i (
        .clk          (clk),
        .reset        (reset),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .wren_i       (wren_i),
        .ch3_on_i     (ch3_on),
        .wave_rdata_i (wave_cpu_rdata),
        .data_o       (data_o),
        .cfg_o        (cfg),
        .mix_o        (mix),
        .trigger_o    (trigger),
        .wave_we_o    (wave_we)
    );

    wave_ram wave_ram_i (
        .clk          (clk),
        .cpu_addr_i   (addr_i[3:0]),
        .cpu_wdata_i  (data_i),
        .cpu_we_i     (wave_we),
        .chan_addr_i  (wave_addr),
        .chan_owns_i  (cfg.dac_on),  // DAC on hands the RAM to the channel
        .cpu_rdata_o  (wave_cpu_rdata),
        .chan_rdata_o (wave_chan_rdata)
    );

    frame_sequencer seq_i (
        .clk        (clk),
        .reset      (reset),
        .len_tick_o (len_tick)
    );

    ////////////////////////////////
    // Audio path

    wave_channel ch3_i (
        .clk         (clk),
        .reset       (reset),
        .power_i     (mix.power),
        .cfg_i       (cfg),
        .trigger_i   (trigger),
        .len_tick_i  (len_tick),
        .wave_byte_i (wave_chan_rdata),
        .wave_addr_o (wave_addr),
        .level_o     (level),
        .ch3_on_o    (ch3_on)
    );

    stereo_mixer mixer_i (
        .level_i  (level),
        .ch3_on_i (ch3_on),
        .mix_i    (mix),
        .out_o    (out)
    );

    assign left_o  = out.left;
    assign right_o = out.right;

endmodule

// ==== tb/apu_checker.sv ====
// APU protocol checks
// Concurrent assertions on the trigger pulse, power gating of the
// outputs and the channel 3 on flag against its DAC
module apu_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  trigger_i,
    input logic                  ch3_on_i,
    input apu_reg_pkg::ch3_cfg_t cfg_i,
    input apu_reg_pkg::mix_ctl_t mix_i,
    input logic [15:0]           left_i,
    input logic [15:0]           right_i
);

    //////////////////////////////
    // Control strobes

    // Trigger lasts one cycle only
    trigger_pulse_a: assert property (@(posedge clk) disable iff (reset)
        trigger_i |=> !trigger_i)
        else $error("trigger stayed high for two cycles");

    //////////////////////////////
    // Audio gating

    // Power off mutes both sides at once
    power_mute_a: assert property (@(posedge clk) disable iff (reset)
        !mix_i.power |-> (left_i == 16'h0000 && right_i == 16'h0000))
        else $error("output not zero while power is off");

    // Channel runs only with the DAC on, flag drops one edge after the DAC
    dac_gate_a: assert property (@(posedge clk) disable iff (reset)
        !cfg_i.dac_on |=> !ch3_on_i)
        else $error("ch3_on high without the DAC on");

endmodule

bind apu_top apu_checker checker_i (
    .clk       (clk),
    .reset     (reset),
    .trigger_i (trigger),
    .ch3_on_i  (ch3_on),
    .cfg_i     (cfg),
    .mix_i     (mix),
    .left_i    (left_o),
    .right_i   (right_o)
);

// ==== tb/apu_tb.sv ====
// APU testbench
// Directed tests over the CPU bus: register map, master clear, wave RAM
// ownership, mixer output, length expiry and power off muting of channel 3
`include "apu_macros.svh"

module apu_tb;

    localparam int CLK_PERIOD = 20;
    localparam int LEN_POLL_CYCLES = 7 * `APU_LEN_TICK_CYCLES;  // 6 ticks plus one spare
    // Rough cycle cost per test plus a margin
    localparam int WATCHDOG_CYCLES = 6 + 40 + 15 + 120 + 60 + (20 + LEN_POLL_CYCLES) + 20 + 200;

    logic        clk;
    logic        reset;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        wren;
    logic [7:0]  rdata;
    logic [15:0] left;
    logic [15:0] right;
    int          errors;
    int          checks;
    integer      seed;
    logic [7:0]  wave_bytes [16];  // Expected wave RAM contents

    apu_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .addr_i  (addr),
        .data_i  (wdata),
        .wren_i  (wren),
        .data_o  (rdata),
        .left_o  (left),
        .right_o (right)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    //////////////////////////////
    // Bus and check helpers

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk);
        addr  = a;
        wdata = d;
        wren  = 1'b1;
        @(negedge clk);  // Write landed on the rising edge in between
        wren = 1'b0;
    endtask

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic expect_read(input logic [15:0] a, input logic [7:0] exp, input string name);
        @(negedge clk);
        addr = a;
        wren = 1'b0;
        #1;  // Read path is combinational
        compare_value(name, {8'h00, rdata}, {8'h00, exp});
    endtask

    // Polls NR52 bit 2 once per cycle until it equals state
    task automatic poll_ch3_flag(input logic state, input int max_cycles, output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < max_cycles && !seen; n++) begin
            @(negedge clk);
            addr = `APU_ADDR_NR52;
            #1;
            if (rdata[2] == state) seen = 1'b1;
        end
    endtask

    // Nibble times master level with six zero bits below
    function automatic logic [15:0] padded_mix(input logic [3:0] sample, input logic [2:0] lvl);
        int prod;
        prod = sample * lvl;
        return 16'(prod * 64);
    endfunction

    //////////////////////////////
    // Directed tests

    task automatic reg_readback;
        expect_read(`APU_ADDR_NR52, 8'h00, "NR52 after reset");
        bus_write(`APU_ADDR_NR50, 8'h77);  // Dropped while power is off
        expect_read(`APU_ADDR_NR50, 8'h00, "NR50 while off");
        bus_write(`APU_ADDR_NR52, 8'h80);
        expect_read(`APU_ADDR_NR52, 8'h80, "NR52");
        bus_write(`APU_ADDR_NR30, 8'h80);
        bus_write(`APU_ADDR_NR31, 8'h3C);
        bus_write(`APU_ADDR_NR32, 8'h40);
        bus_write(`APU_ADDR_NR33, 8'hA5);
        bus_write(`APU_ADDR_NR34, 8'h45);  // No trigger bit
        bus_write(`APU_ADDR_NR50, 8'h53);
        bus_write(`APU_ADDR_NR51, 8'h44);
        expect_read(`APU_ADDR_NR30, 8'h80, "NR30");
        expect_read(`APU_ADDR_NR31, 8'h3C, "NR31");
        expect_read(`APU_ADDR_NR32, 8'h40, "NR32");
        expect_read(`APU_ADDR_NR33, 8'hA5, "NR33");
        expect_read(`APU_ADDR_NR34, 8'h45, "NR34");
        expect_read(`APU_ADDR_NR50, 8'h53, "NR50");
        expect_read(`APU_ADDR_NR51, 8'h44, "NR51");
        expect_read(16'hFF10, `APU_READ_DEFAULT, "unused 0xFF10");  // Dropped channel 1
        expect_read(16'hFF40, `APU_READ_DEFAULT, "unused 0xFF40");
    endtask

    task automatic master_clear;
        bus_write(`APU_ADDR_NR52, 8'h00);
        expect_read(`APU_ADDR_NR30, 8'h00, "NR30 after clear");
        expect_read(`APU_ADDR_NR31, 8'h00, "NR31 after clear");
        expect_read(`APU_ADDR_NR32, 8'h00, "NR32 after clear");
        expect_read(`APU_ADDR_NR33, 8'h00, "NR33 after clear");
        expect_read(`APU_ADDR_NR34, 8'h00, "NR34 after clear");
        expect_read(`APU_ADDR_NR50, 8'h00, "NR50 after clear");
        expect_read(`APU_ADDR_NR51, 8'h00, "NR51 after clear");
        expect_read(`APU_ADDR_NR52, 8'h00, "NR52 after clear");
    endtask

    task automatic wave_ram_access;
        int i;
        bus_write(`APU_ADDR_NR52, 8'h80);  // DAC stays off from the clear
        for (i = 0; i < 16; i++) begin
            wave_bytes[i] = 8'($random(seed));
            bus_write(`APU_WAVE_BASE + 16'(i), wave_bytes[i]);
        end
        for (i = 0; i < 16; i++) expect_read(`APU_WAVE_BASE + 16'(i), wave_bytes[i], "wave RAM");
        bus_write(`APU_ADDR_NR30, 8'h80);  // Channel takes the RAM
        for (i = 0; i < 16; i++) begin
            expect_read(`APU_WAVE_BASE + 16'(i), `APU_READ_DEFAULT, "wave RAM while DAC on");
        end
        bus_write(16'hFF35, ~wave_bytes[5]);  // Must be dropped
        bus_write(`APU_ADDR_NR30, 8'h00);
        expect_read(16'hFF35, wave_bytes[5], "wave RAM 0xFF35 after blocked write");
    endtask

    task automatic mix_output;
        int   i;
        logic seen;
        for (i = 0; i < 16; i++) bus_write(`APU_WAVE_BASE + 16'(i), 8'hAA);
        bus_write(`APU_ADDR_NR30, 8'h80);
        bus_write(`APU_ADDR_NR51, 8'h40);  // Channel 3 left only
        bus_write(`APU_ADDR_NR50, 8'h50);  // Left level 5
        bus_write(`APU_ADDR_NR32, 8'h20);  // Volume code 1
        bus_write(`APU_ADDR_NR33, 8'h00);
        bus_write(`APU_ADDR_NR34, 8'h87);  // Trigger without length
        poll_ch3_flag(1'b1, 8, seen);
        assert (seen) else begin
            errors++;
            $display("Channel 3 did not switch on after the NR34 trigger in the mix test");
        end
        compare_value("left_o", left, padded_mix(4'hA, 3'd5));
        compare_value("right_o", right, 16'h0000);
        bus_write(`APU_ADDR_NR32, 8'h40);  // Volume code 2
        @(negedge clk);  // Level register one cycle behind
        #1;
        compare_value("left_o", left, padded_mix(4'hA >> 1, 3'd5));
        compare_value("right_o", right, 16'h0000);
    endtask

    task automatic length_expiry;
        logic seen;
        bus_write(`APU_ADDR_NR30, 8'h00);  // Stop the channel
        bus_write(`APU_ADDR_NR31, 8'd250);  // Six length steps
        bus_write(`APU_ADDR_NR30, 8'h80);
        bus_write(`APU_ADDR_NR34, 8'hC7);  // Trigger with length enabled
        poll_ch3_flag(1'b1, 8, seen);
        assert (seen) else begin
            errors++;
            $display("Channel 3 did not switch on after the NR34 trigger in the length test");
        end
        poll_ch3_flag(1'b0, LEN_POLL_CYCLES, seen);
        assert (seen) else begin
            errors++;
            $display("Channel 3 still on after the length counter should have expired");
        end
        compare_value("left_o", left, 16'h0000);
        compare_value("right_o", right, 16'h0000);
    endtask

    // Power drop while the channel plays mutes the outputs at once
    task automatic power_off_mute;
        logic seen;
        bus_write(`APU_ADDR_NR34, 8'h87);  // Retrigger without length
        poll_ch3_flag(1'b1, 8, seen);
        assert (seen) else begin
            errors++;
            $display("Channel 3 did not switch on after the NR34 trigger in the power test");
        end
        compare_value("left_o", left, padded_mix(4'hA >> 1, 3'd5));
        bus_write(`APU_ADDR_NR52, 8'h00);  // On flag still set for one more cycle
        #1;
        compare_value("left_o", left, 16'h0000);
    endtask

    //////////////////////////////
    // Main sequence and watchdog

    initial begin
        reset  = 1'b1;
        addr   = 16'h0000;
        wdata  = 8'h00;
        wren   = 1'b0;
        errors = 0;
        checks = 0;
        seed   = 29;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reg_readback();
        master_clear();
        wave_ram_access();
        mix_output();
        length_expiry();
        power_off_mute();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/apu_reg_pkg.sv
verilog/apu_audio_pkg.sv
verilog/apu_regs.sv
verilog/wave_ram.sv
verilog/frame_sequencer.sv
verilog/wave_channel.sv
verilog/stereo_mixer.sv
verilog/apu_top.sv
tb/apu_checker.sv
tb/apu_tb.sv

// ==== Makefile ====
# Verilator build, run and lint of the APU testbench

SRCS := vlog.f $(wildcard include/*.svh verilog/*.sv tb/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/Vapu_tb: $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module apu_tb

run: obj_dir/Vapu_tb
	./obj_dir/Vapu_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module apu_tb

clean:
	rm -rf obj_dir sim.log
